// ==== compile.f ====
hw/kbd_pkg.sv
hw/ps2_rx.sv
hw/scan_decoder.sv
hw/key_state.sv
hw/keyboard_tracker.sv
dv/keyboard_tracker_props.sv
dv/tb_keyboard_tracker.sv

// ==== Bender.yml ====
package:
  name: keyboard_tracker

sources:
  - files:
      - hw/kbd_pkg.sv
      - hw/ps2_rx.sv
      - hw/scan_decoder.sv
      - hw/key_state.sv
      - hw/keyboard_tracker.sv
  - target: simulation
    files:
      - dv/keyboard_tracker_props.sv
      - dv/tb_keyboard_tracker.sv

// ==== dv/keyboard_cases.txt ====
# kind byte held pulse frame_err, values in hex, held and pulse are key vectors
# kind is good, parity (bad parity bit), trunc (cut after four bits) or reset
good   1D 010 010 0
good   F0 010 000 0
good   1D 000 000 0
good   E0 000 000 0
good   74 002 002 0
good   E0 002 000 0
good   F0 002 000 0
good   74 000 000 0
good   74 000 000 0
good   1C 020 020 0
good   29 120 100 0
good   1C 120 000 0
good   E0 120 000 0
good   75 124 004 0
good   F0 124 000 0
good   1C 104 000 0
parity 23 104 000 1
trunc  5A 104 000 0
good   5A 304 200 0
good   F0 304 000 0
reset  00 000 000 0
good   29 100 100 0
good   F0 100 000 0
good   29 000 000 0

// ==== dv/tb_keyboard_tracker.sv ====
// Testbench for the PS/2 keyboard tracker
// Bit-bangs PS/2 frames listed in a case file and checks the held vector,
// the pulses seen during each byte and the frame error strobe
module tb_keyboard_tracker
    import kbd_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned RX_TIMEOUT   = 200;
    localparam int          HALF_PERIOD  = 20;
    localparam int          DRIVE_DELAY  = 10;
    localparam int          SETTLE_QUIET = 8;
    localparam int          SETTLE_LIMIT = 200;
    localparam string       CASE_FILE    = "dv/keyboard_cases.txt";

    logic     CLOCK_50;
    logic     reset;
    logic     ps2_clk;
    logic     ps2_dat;
    key_vec_t key_held;
    key_vec_t key_pulse;
    logic     frame_err;

    // Pulses and frame errors seen since the current case began
    key_vec_t pulse_seen;
    logic     err_seen;
    key_vec_t last_pulse;
    int       case_no;

    keyboard_tracker #(
        .RX_TIMEOUT_CYCLES(RX_TIMEOUT)
    ) UUT (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .i_ps2_clk  (ps2_clk),
        .i_ps2_dat  (ps2_dat),
        .o_key_held (key_held),
        .o_key_pulse(key_pulse),
        .o_frame_err(frame_err)
    );

    // 100 ns system clock
    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_keys(input string name, input key_vec_t actual,
                              input key_vec_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s is 0x%03h, expected 0x%03h (case %0d)",
                               name, actual, expected, case_no));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s is 0x%0h, expected 0x%0h (case %0d)",
                               name, actual, expected, case_no));
        end
    endtask

    // Inputs move a fixed delay after the rising edge
    task automatic step_cycle();
        @(posedge CLOCK_50);
        #(DRIVE_DELAY);
    endtask

    // Reset low across two rising edges
    task automatic apply_reset();
        reset = 1'b0;
        repeat (2) step_cycle();
        reset = 1'b1;
    endtask

    // Data changes while the PS/2 clock is high and is sampled on the fall
    task automatic send_bit(input logic value);
        ps2_dat = value;
        repeat (HALF_PERIOD) step_cycle();
        ps2_clk = 1'b0;
        repeat (HALF_PERIOD) step_cycle();
        ps2_clk = 1'b1;
    endtask

    task automatic send_frame(input scan_byte_t data, input logic bad_parity,
                              input logic truncate);
        logic [10:0] bits;
        int          count;
        int          i;
        // Stop, odd parity, data LSB first, start
        bits  = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
        count = truncate ? 4 : 11;
        step_cycle();
        for (i = 0; i < count; i++) begin
            send_bit(bits[i]);
        end
        ps2_dat = 1'b1;
        // Stall well past the receiver timeout
        if (truncate) begin
            repeat (2 * RX_TIMEOUT) step_cycle();
        end
    endtask

    // Done once outputs hold still for a few cycles
    task automatic wait_settled();
        key_vec_t last_held;
        int       quiet;
        int       cycles;
        last_held = key_held;
        quiet     = 0;
        cycles    = 0;
        while (quiet < SETTLE_QUIET) begin
            @(negedge CLOCK_50);
            cycles++;
            if (cycles > SETTLE_LIMIT) begin
                fail_run("Timed out waiting for the DUT outputs to settle");
            end
            if (key_pulse == '0 && !frame_err && key_held == last_held) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            last_held = key_held;
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = 0;
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // Sampled mid-cycle, where DUT outputs are stable
    always @(negedge CLOCK_50) begin
        if (reset) begin
            check_keys("o_key_pulse overlap", key_pulse & last_pulse, '0);
            pulse_seen = pulse_seen | key_pulse;
            err_seen   = err_seen | frame_err;
        end
        last_pulse = key_pulse;
    end

    initial begin
        int          fd;
        int          n;
        string       kind;
        logic [31:0] byte_val;
        logic [31:0] held_val;
        logic [31:0] pulse_val;
        logic [31:0] err_val;

        reset      = 1'b0;
        ps2_clk    = 1'b1;
        ps2_dat    = 1'b1;
        pulse_seen = '0;
        err_seen   = 1'b0;
        last_pulse = '0;
        case_no    = 0;
        apply_reset();

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            fail_run("Could not open the case file");
        end
        while ($fscanf(fd, " %s", kind) == 1) begin
            if (kind.substr(0, 0) == "#") begin
                skip_line(fd);
            end else begin
                n = $fscanf(fd, " %h %h %h %h", byte_val, held_val, pulse_val, err_val);
                case_no++;
                if (n != 4) begin
                    fail_run($sformatf("Case %0d in the case file is malformed", case_no));
                end
                pulse_seen = '0;
                err_seen   = 1'b0;
                if (kind == "good") begin
                    send_frame(byte_val[7:0], 1'b0, 1'b0);
                end else if (kind == "parity") begin
                    send_frame(byte_val[7:0], 1'b1, 1'b0);
                end else if (kind == "trunc") begin
                    send_frame(byte_val[7:0], 1'b0, 1'b1);
                end else if (kind == "reset") begin
                    step_cycle();
                    apply_reset();
                end else begin
                    fail_run($sformatf("Case %0d has an unknown kind", case_no));
                end
                wait_settled();
                check_keys("o_key_held", key_held, held_val[NUM_KEYS-1:0]);
                check_keys("o_key_pulse", pulse_seen, pulse_val[NUM_KEYS-1:0]);
                check_flag("o_frame_err", err_seen, err_val[0]);
            end
        end
        $fclose(fd);

        if (case_no == 0) begin
            fail_run("The case file held no cases");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// ==== dv/keyboard_tracker_props.sv ====
// Keyboard tracker output and strobe rules
// Bound into the top level, checks pulses against held keys,
// one-cycle pulses and strobes, and the values right after reset
module keyboard_tracker_props
    import kbd_pkg::*;
(
    input logic     CLOCK_50,
    input logic     reset,
    input key_vec_t i_key_held,
    input key_vec_t i_key_pulse,
    input logic     i_frame_err,
    input logic     i_byte_valid,
    input logic     i_key_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // A pulse only ever marks a key that is down
    pulse_held: assert property (@(posedge CLOCK_50) disable iff (!reset)
        (i_key_pulse & ~i_key_held) == '0)
        else $error("o_key_pulse set for a key that is not held");

    // No key pulses in two cycles in a row
    pulse_single: assert property (@(posedge CLOCK_50) disable iff (!reset)
        (i_key_pulse & $past(i_key_pulse)) == '0)
        else $error("o_key_pulse bit high for two cycles");

    // Strobes between the stages last one cycle
    frame_err_single: assert property (@(posedge CLOCK_50) disable iff (!reset)
        i_frame_err |=> !i_frame_err)
        else $error("o_frame_err high for two cycles");

    byte_valid_single: assert property (@(posedge CLOCK_50) disable iff (!reset)
        i_byte_valid |=> !i_byte_valid)
        else $error("Byte strobe high for two cycles");

    key_valid_single: assert property (@(posedge CLOCK_50) disable iff (!reset)
        i_key_valid |=> !i_key_valid)
        else $error("Key event strobe high for two cycles");

    // One cycle of reset clears outputs and strobes
    reset_clears: assert property (@(posedge CLOCK_50)
        !reset |=> (i_key_held == '0 && i_key_pulse == '0 && !i_frame_err
                    && !i_byte_valid && !i_key_valid))
        else $error("Outputs or strobes not cleared by reset");

endmodule

bind keyboard_tracker keyboard_tracker_props u_props (
    .CLOCK_50    (CLOCK_50),
    .reset       (reset),
    .i_key_held  (o_key_held),
    .i_key_pulse (o_key_pulse),
    .i_frame_err (o_frame_err),
    .i_byte_valid(byte_valid),
    .i_key_valid (key_valid)
);

// ==== hw/keyboard_tracker.sv ====
// PS/2 keyboard tracker top level
// Receiver, scan-code decoder and key state in a chain
// Gives held and first-press pulse outputs for ten keys
// plus a strobe for frames dropped on a bad start, parity or stop bit
module keyboard_tracker
    import kbd_pkg::*;
#(
    parameter int unsigned RX_TIMEOUT_CYCLES = 5000
) (
    input  logic     CLOCK_50,
    input  logic     reset,
    input  logic     i_ps2_clk,
    input  logic     i_ps2_dat,
    output key_vec_t o_key_held,
    output key_vec_t o_key_pulse,
    output logic     o_frame_err
);

    // Receiver to decoder
    logic       byte_valid;
    scan_byte_t rx_byte;

    // Decoder to key state
    logic     key_valid;
    key_idx_t key_idx;
    logic     key_make;

    ps2_rx #(
        .RX_TIMEOUT_CYCLES(RX_TIMEOUT_CYCLES)
    ) u_ps2_rx (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .i_ps2_clk   (i_ps2_clk),
        .i_ps2_dat   (i_ps2_dat),
        .o_byte_valid(byte_valid),
        .o_byte      (rx_byte),
        .o_frame_err (o_frame_err)
    );

    scan_decoder u_scan_decoder (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .i_byte_valid(byte_valid),
        .i_byte      (rx_byte),
        .o_key_valid (key_valid),
        .o_key_idx   (key_idx),
        .o_key_make  (key_make)
    );

    key_state u_key_state (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .i_key_valid(key_valid),
        .i_key_idx  (key_idx),
        .i_key_make (key_make),
        .o_key_held (o_key_held),
        .o_key_pulse(o_key_pulse)
    );

endmodule

// ==== hw/key_state.sv ====
// Key state registers
// One press bit per key follows make and break events
// The lock bit trails press by a cycle to form a one-cycle pulse
module key_state
    import kbd_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     reset,
    input  logic     i_key_valid,
    input  key_idx_t i_key_idx,
    input  logic     i_key_make,
    output key_vec_t o_key_held,
    output key_vec_t o_key_pulse
);

    key_vec_t press;
    key_vec_t lock;

    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            press <= '0;
            lock  <= '0;
        end else begin
            // Lock copies press every cycle
            lock <= press;
            // Typematic repeat of a make rewrites 1 over 1, no new pulse
            if (i_key_valid) begin
                press[i_key_idx] <= i_key_make;
            end
        end
    end

    assign o_key_held = press;

    // High only in the first cycle after press rises
    assign o_key_pulse = press & ~lock;

endmodule

// ==== hw/scan_decoder.sv ====
// Scan Code Set 2 decoder
// Tracks the E0 and F0 prefixes in a small FSM and turns each code
// byte that matches a tracked key into a make or break event
module scan_decoder
    import kbd_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       i_byte_valid,
    input  scan_byte_t i_byte,
    output logic       o_key_valid,
    output key_idx_t   o_key_idx,
    output logic       o_key_make
);

    decode_state_t state;

    logic     is_prefix;
    logic     in_secondary;
    logic     in_make;
    logic     key_hit;
    key_idx_t key_hit_idx;

    assign is_prefix    = (i_byte == PREFIX_SECONDARY) || (i_byte == PREFIX_BREAK);
    assign in_secondary = (state == SECONDARY_MAKE) || (state == SECONDARY_BREAK);
    assign in_make      = (state == MAKE) || (state == SECONDARY_MAKE);

    // Table lookup, the prefix flag must match too
    always_comb begin
        key_hit = lookup_key(i_byte, in_secondary, key_hit_idx);
    end

    // Prefix FSM and event strobe
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            state       <= MAKE;
            o_key_valid <= 1'b0;
        end else begin
            o_key_valid <= 1'b0;
            if (i_byte_valid) begin
                if (i_byte == PREFIX_SECONDARY) begin
                    state <= SECONDARY_MAKE;
                end else if (i_byte == PREFIX_BREAK) begin
                    case (state)
                        MAKE:           state <= BREAK;
                        SECONDARY_MAKE: state <= SECONDARY_BREAK;
                        // Repeated F0 leaves a break pending
                        default:        state <= state;
                    endcase
                end else begin
                    // Any code byte ends the sequence
                    state       <= MAKE;
                    o_key_valid <= key_hit;
                end
            end
        end
    end

    // Event payload, only meaningful with the strobe
    always_ff @(posedge CLOCK_50) begin
        if (i_byte_valid && !is_prefix) begin
            o_key_idx  <= key_hit_idx;
            o_key_make <= in_make;
        end
    end

endmodule

// ==== hw/ps2_rx.sv ====
// PS/2 device-to-host frame receiver
// Synchronizes the PS/2 clock and data lines, samples data on each
// falling edge of the PS/2 clock and assembles 11-bit frames
// Good frames give a one-cycle byte strobe, bad ones a one-cycle error
// A stalled partial frame is dropped after RX_TIMEOUT_CYCLES
module ps2_rx
    import kbd_pkg::*;
#(
    parameter int unsigned RX_TIMEOUT_CYCLES = 5000
) (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       i_ps2_clk,
    input  logic       i_ps2_dat,
    output logic       o_byte_valid,
    output scan_byte_t o_byte,
    output logic       o_frame_err
);

    localparam int TIMEOUT_W = $clog2(RX_TIMEOUT_CYCLES + 1);
    localparam logic [TIMEOUT_W-1:0] TIMEOUT_LAST = TIMEOUT_W'(RX_TIMEOUT_CYCLES - 1);

    // Start, 8 data, parity, stop
    localparam logic [3:0] LAST_BIT = 4'd10;

    // Clock keeps one extra stage for edge detection
    logic [2:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_fall;

    logic [10:0]          frame;
    logic [3:0]           bit_cnt;
    logic                 frame_done;
    logic                 frame_good;
    logic [TIMEOUT_W-1:0] idle_cnt;

    // Both lines see the same two-flop delay, so they stay aligned
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            // Idle bus is high, so no false edge out of reset
            clk_sync <= '1;
            dat_sync <= '1;
        end else begin
            clk_sync <= {clk_sync[1:0], i_ps2_clk};
            dat_sync <= {dat_sync[0], i_ps2_dat};
        end
    end

    assign clk_fall = clk_sync[2] & ~clk_sync[1];

    // Shift in from the top, first bit ends up in frame[0]
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            frame <= {dat_sync[1], frame[10:1]};
        end
    end

    // Bit counter and stall timeout
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == LAST_BIT) begin
                    // Stop bit sampled, frame complete
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != '0) begin
                // Mid-frame with no edge, count toward giving up
                if (idle_cnt == TIMEOUT_LAST) begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // Start low, odd parity over data and parity, stop high
    assign frame_good = ~frame[0] & (^frame[9:1]) & frame[10];

    // Strobes one cycle after the stop bit sample
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            o_byte_valid <= 1'b0;
            o_frame_err  <= 1'b0;
        end else begin
            o_byte_valid <= frame_done & frame_good;
            o_frame_err  <= frame_done & ~frame_good;
        end
    end

    // Data byte held until the next frame ends
    always_ff @(posedge CLOCK_50) begin
        if (frame_done) begin
            o_byte <= frame[8:1];
        end
    end

endmodule

// ==== hw/kbd_pkg.sv ====
// Keyboard tracker shared definitions
// Key indices and their Scan Code Set 2 codes, prefix bytes,
// decoder states and the scan-code lookup used by the decoder
package kbd_pkg;

    localparam int NUM_KEYS = 10;

    typedef logic [3:0]          key_idx_t;
    typedef logic [NUM_KEYS-1:0] key_vec_t;
    typedef logic [7:0]          scan_byte_t;

    // What the decoder expects the next byte to be
    typedef enum logic [1:0] {
        MAKE            = 2'b00,
        BREAK           = 2'b01,
        SECONDARY_MAKE  = 2'b10,
        SECONDARY_BREAK = 2'b11
    } decode_state_t;

    // One tracked key: output bit, code, and whether E0 precedes it
    typedef struct packed {
        key_idx_t   idx;
        scan_byte_t code;
        logic       secondary;
    } key_def_t;

    localparam scan_byte_t PREFIX_SECONDARY = 8'hE0;
    localparam scan_byte_t PREFIX_BREAK     = 8'hF0;

    // Arrows share codes with keypad keys, told apart by E0
    localparam key_def_t KEY_LEFT  = '{idx: 4'd0, code: 8'h6B, secondary: 1'b1};
    localparam key_def_t KEY_RIGHT = '{idx: 4'd1, code: 8'h74, secondary: 1'b1};
    localparam key_def_t KEY_UP    = '{idx: 4'd2, code: 8'h75, secondary: 1'b1};
    localparam key_def_t KEY_DOWN  = '{idx: 4'd3, code: 8'h72, secondary: 1'b1};
    localparam key_def_t KEY_W     = '{idx: 4'd4, code: 8'h1D, secondary: 1'b0};
    localparam key_def_t KEY_A     = '{idx: 4'd5, code: 8'h1C, secondary: 1'b0};
    localparam key_def_t KEY_S     = '{idx: 4'd6, code: 8'h1B, secondary: 1'b0};
    localparam key_def_t KEY_D     = '{idx: 4'd7, code: 8'h23, secondary: 1'b0};
    localparam key_def_t KEY_SPACE = '{idx: 4'd8, code: 8'h29, secondary: 1'b0};
    localparam key_def_t KEY_ENTER = '{idx: 4'd9, code: 8'h5A, secondary: 1'b0};

    localparam key_def_t KEY_TABLE [NUM_KEYS] = '{
        KEY_LEFT, KEY_RIGHT, KEY_UP, KEY_DOWN,
        KEY_W, KEY_A, KEY_S, KEY_D,
        KEY_SPACE, KEY_ENTER
    };

    // Returns 1 when code and prefix match a tracked key
    function automatic logic lookup_key(
        input  scan_byte_t code,
        input  logic       secondary,
        output key_idx_t   idx
    );
        logic found;
        found = 1'b0;
        idx   = '0;
        for (int i = 0; i < NUM_KEYS; i++) begin
            if (KEY_TABLE[i].code == code && KEY_TABLE[i].secondary == secondary) begin
                found = 1'b1;
                idx   = KEY_TABLE[i].idx;
            end
        end
        return found;
    endfunction

endpackage
